// ==== rtl/aurora_macros.svh ====
`ifndef AURORA_MACROS_SVH
`define AURORA_MACROS_SVH

// Bus and stream widths
`define AXI_ADDR_W 6
`define DATA_W 32

// Register word indices, taken from address bits 5..2
`define REG_STAT   4'd0
`define REG_CTRL   4'd1
`define REG_TX_CNT 4'd2
`define REG_RX_CNT 4'd3

`define LOOP_DEPTH_LOG2 4  // 16 words of loopback storage

`define CTRL_RESET_STRIP 1'b1  // Strip trailing word out of reset

`endif

// ==== rtl/aurora_pkg.sv ====
`include "aurora_macros.svh"

package aurora_pkg;

   // One stream or bus word
   typedef logic [`DATA_W-1:0] word_t;

   // Control register, seen as a plain word on the bus
   // or as individual control fields inside the design
   typedef union packed {
      word_t raw;
      struct packed {
         logic [`DATA_W-3:0] rsvd;
         logic               strip_en;  // Drop trailing sequence word on RX
         logic               loopback;  // Replay received words toward the link
      } f;
   } ctrl_reg_u;

endpackage

// ==== rtl/stream_if.sv ====
`include "aurora_macros.svh"

// Word stream with valid/ready handshake and end-of-packet marker
interface stream_if;
   aurora_pkg::word_t tdata;
   logic              tlast;
   logic              tvalid;
   logic              tready;

   modport src (
      output tdata,
      output tlast,
      output tvalid,
      input  tready
   );

   modport snk (
      input  tdata,
      input  tlast,
      input  tvalid,
      output tready
   );
endinterface

// ==== rtl/reg_slave.sv ====
`include "aurora_macros.svh"

module reg_slave (
   input  logic                     usr_clk,
   input  logic                     S_AXI_ARESETN,
   // Write channel
   input  logic [`AXI_ADDR_W-1:0]   S_AXI_AWADDR,
   input  logic                     S_AXI_AWVALID,
   output logic                     S_AXI_AWREADY,
   input  aurora_pkg::word_t        S_AXI_WDATA,
   input  logic                     S_AXI_WVALID,
   output logic                     S_AXI_WREADY,
   output logic                     S_AXI_BVALID,
   input  logic                     S_AXI_BREADY,
   // Read channel
   input  logic [`AXI_ADDR_W-1:0]   S_AXI_ARADDR,
   input  logic                     S_AXI_ARVALID,
   output logic                     S_AXI_ARREADY,
   output aurora_pkg::word_t        S_AXI_RDATA,
   output logic                     S_AXI_RVALID,
   input  logic                     S_AXI_RREADY,
   // Status and counters from the datapath
   input  logic                     channel_up,
   input  logic                     overflow,
   input  aurora_pkg::word_t        tx_pkt_cnt,
   input  aurora_pkg::word_t        rx_pkt_cnt,
   output aurora_pkg::ctrl_reg_u    ctrl
);
   import aurora_pkg::*;

   logic      wr_start;   // Address and data both present, no write in flight
   logic      wr_accept;  // Handshake cycle of the write
   logic      rd_start;
   logic      rd_accept;
   ctrl_reg_u wdata_u;
   word_t     rd_mux;

   assign wr_start  = !S_AXI_AWREADY && S_AXI_AWVALID && S_AXI_WVALID && !S_AXI_BVALID;
   assign wr_accept = S_AXI_AWREADY && S_AXI_AWVALID && S_AXI_WREADY && S_AXI_WVALID;
   assign rd_start  = !S_AXI_ARREADY && S_AXI_ARVALID && !S_AXI_RVALID;
   assign rd_accept = S_AXI_ARREADY && S_AXI_ARVALID;

   assign wdata_u.raw = S_AXI_WDATA;

   // Write handshake and response
   always_ff @(posedge usr_clk) begin
      if (!S_AXI_ARESETN) begin
         S_AXI_AWREADY <= 1'b0;
         S_AXI_WREADY  <= 1'b0;
         S_AXI_BVALID  <= 1'b0;
      end else begin
         S_AXI_AWREADY <= wr_start;  // Single-cycle pulse
         S_AXI_WREADY  <= wr_start;
         if (wr_accept) begin
            S_AXI_BVALID <= 1'b1;
         end else if (S_AXI_BVALID && S_AXI_BREADY) begin
            S_AXI_BVALID <= 1'b0;
         end
      end
   end

   // Control register, only the two field bits are writable
   always_ff @(posedge usr_clk) begin
      if (!S_AXI_ARESETN) begin
         ctrl.raw <= {{(`DATA_W-2){1'b0}}, `CTRL_RESET_STRIP, 1'b0};
      end else if (wr_accept && S_AXI_AWADDR[`AXI_ADDR_W-1:2] == `REG_CTRL) begin
         ctrl.f.strip_en <= wdata_u.f.strip_en;
         ctrl.f.loopback <= wdata_u.f.loopback;
      end
   end

   // Read mux on the address as presented during acceptance
   always_comb begin
      case (S_AXI_ARADDR[`AXI_ADDR_W-1:2])
         `REG_STAT:   rd_mux = {{(`DATA_W-2){1'b0}}, overflow, channel_up};
         `REG_CTRL:   rd_mux = ctrl.raw;
         `REG_TX_CNT: rd_mux = tx_pkt_cnt;
         `REG_RX_CNT: rd_mux = rx_pkt_cnt;
         default:     rd_mux = '0;
      endcase
   end

   // Read handshake
   always_ff @(posedge usr_clk) begin
      if (!S_AXI_ARESETN) begin
         S_AXI_ARREADY <= 1'b0;
         S_AXI_RVALID  <= 1'b0;
      end else begin
         S_AXI_ARREADY <= rd_start;
         if (rd_accept) begin
            S_AXI_RVALID <= 1'b1;
         end else if (S_AXI_RVALID && S_AXI_RREADY) begin
            S_AXI_RVALID <= 1'b0;
         end
      end
   end

   // Data held steady while RVALID waits for RREADY
   always_ff @(posedge usr_clk) begin
      if (rd_accept) begin
         S_AXI_RDATA <= rd_mux;
      end
   end

endmodule

// ==== rtl/tx_framer.sv ====
`include "aurora_macros.svh"

module tx_framer (
   input  logic              usr_clk,
   input  logic              S_AXI_ARESETN,
   input  logic              s_axis_tvalid,
   input  aurora_pkg::word_t s_axis_tdata,
   input  logic              s_axis_tlast,
   output logic              s_axis_tready,
   stream_if.snk             loop_s,
   input  logic              loopback,
   output logic              link_tx_tvalid,
   output aurora_pkg::word_t link_tx_tdata,
   output logic              link_tx_tlast,
   input  logic              link_tx_tready,
   output aurora_pkg::word_t tx_pkt_cnt
);
   import aurora_pkg::*;

   localparam logic ST_PAYLOAD = 1'b0;
   localparam logic ST_SEQ     = 1'b1;

   logic  state;
   logic  last_taken;  // Final user word of a packet accepted by the link
   word_t seq_word;

   assign seq_word   = tx_pkt_cnt;  // Packets sent before this one
   assign last_taken = (state == ST_PAYLOAD) && s_axis_tvalid && s_axis_tlast && link_tx_tready;

   // Source select toward the link
   always_comb begin
      s_axis_tready = 1'b0;
      loop_s.tready = 1'b0;
      if (loopback) begin
         link_tx_tvalid = loop_s.tvalid;
         link_tx_tdata  = loop_s.tdata;
         link_tx_tlast  = loop_s.tlast;  // Replayed words keep their framing
         loop_s.tready  = link_tx_tready;
      end else if (state == ST_PAYLOAD) begin
         link_tx_tvalid = s_axis_tvalid;
         link_tx_tdata  = s_axis_tdata;
         link_tx_tlast  = 1'b0;  // Packet ends on the sequence word
         s_axis_tready  = link_tx_tready;
      end else begin
         link_tx_tvalid = 1'b1;
         link_tx_tdata  = seq_word;
         link_tx_tlast  = 1'b1;
      end
   end

   always_ff @(posedge usr_clk) begin
      if (!S_AXI_ARESETN) begin
         state      <= ST_PAYLOAD;
         tx_pkt_cnt <= '0;
      end else if (!loopback) begin
         if (last_taken) begin
            state <= ST_SEQ;
         end else if (state == ST_SEQ && link_tx_tready) begin
            state      <= ST_PAYLOAD;
            tx_pkt_cnt <= tx_pkt_cnt + 1'b1;  // Sequence word went out
         end
      end
   end

endmodule

// ==== rtl/loop_fifo.sv ====
`include "aurora_macros.svh"

module loop_fifo (
   input  logic              usr_clk,
   input  logic              S_AXI_ARESETN,
   input  logic              link_rx_tvalid,
   input  aurora_pkg::word_t link_rx_tdata,
   input  logic              link_rx_tlast,
   stream_if.src             loop_s,
   output logic              overflow
);
   import aurora_pkg::*;

   localparam int DEPTH = 1 << `LOOP_DEPTH_LOG2;

   word_t mem_data [DEPTH];
   logic  mem_last [DEPTH];

   // Extra top bit tells full from empty
   logic [`LOOP_DEPTH_LOG2:0] wr_ptr;
   logic [`LOOP_DEPTH_LOG2:0] rd_ptr;
   logic                      full;
   logic                      empty;

   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[`LOOP_DEPTH_LOG2] != rd_ptr[`LOOP_DEPTH_LOG2]) &&
                  (wr_ptr[`LOOP_DEPTH_LOG2-1:0] == rd_ptr[`LOOP_DEPTH_LOG2-1:0]);

   assign loop_s.tvalid = !empty;
   assign loop_s.tdata  = mem_data[rd_ptr[`LOOP_DEPTH_LOG2-1:0]];
   assign loop_s.tlast  = mem_last[rd_ptr[`LOOP_DEPTH_LOG2-1:0]];

   always_ff @(posedge usr_clk) begin
      if (link_rx_tvalid && !full) begin
         mem_data[wr_ptr[`LOOP_DEPTH_LOG2-1:0]] <= link_rx_tdata;
         mem_last[wr_ptr[`LOOP_DEPTH_LOG2-1:0]] <= link_rx_tlast;
      end
   end

   always_ff @(posedge usr_clk) begin
      if (!S_AXI_ARESETN) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         overflow <= 1'b0;
      end else begin
         if (link_rx_tvalid) begin
            if (full) overflow <= 1'b1;  // Word lost, flag stays until reset
            else      wr_ptr   <= wr_ptr + 1'b1;
         end
         if (loop_s.tvalid && loop_s.tready) rd_ptr <= rd_ptr + 1'b1;
      end
   end

endmodule

// ==== rtl/rx_strip.sv ====
`include "aurora_macros.svh"

module rx_strip (
   input  logic              usr_clk,
   input  logic              S_AXI_ARESETN,
   input  logic              link_rx_tvalid,
   input  aurora_pkg::word_t link_rx_tdata,
   input  logic              link_rx_tlast,
   input  logic              strip_en,
   output logic              m_axis_tvalid,
   output aurora_pkg::word_t m_axis_tdata,
   output logic              m_axis_tlast,
   output aurora_pkg::word_t rx_pkt_cnt
);
   import aurora_pkg::*;

   word_t hold_data;   // Previous word of the current packet
   logic  hold_valid;

   // Control state
   always_ff @(posedge usr_clk) begin
      if (!S_AXI_ARESETN) begin
         m_axis_tvalid <= 1'b0;
         hold_valid    <= 1'b0;
         rx_pkt_cnt    <= '0;
      end else begin
         m_axis_tvalid <= link_rx_tvalid && (!strip_en || hold_valid);
         if (link_rx_tvalid) begin
            // Last word is the sequence number and never gets held
            hold_valid <= strip_en && !link_rx_tlast;
            if (link_rx_tlast) rx_pkt_cnt <= rx_pkt_cnt + 1'b1;
         end
      end
   end

   // Payload path
   always_ff @(posedge usr_clk) begin
      if (link_rx_tvalid) begin
         hold_data    <= link_rx_tdata;
         m_axis_tdata <= strip_en ? hold_data : link_rx_tdata;
         m_axis_tlast <= link_rx_tlast;  // Held word inherits the end marker
      end
   end

endmodule

// ==== rtl/aurora_shell.sv ====
`include "aurora_macros.svh"

module aurora_shell (
   input  logic                     usr_clk,
   input  logic                     S_AXI_ARESETN,
   // AXI-Lite register bus
   input  logic [`AXI_ADDR_W-1:0]   S_AXI_AWADDR,
   input  logic                     S_AXI_AWVALID,
   output logic                     S_AXI_AWREADY,
   input  aurora_pkg::word_t        S_AXI_WDATA,
   input  logic                     S_AXI_WVALID,
   output logic                     S_AXI_WREADY,
   output logic                     S_AXI_BVALID,
   input  logic                     S_AXI_BREADY,
   input  logic [`AXI_ADDR_W-1:0]   S_AXI_ARADDR,
   input  logic                     S_AXI_ARVALID,
   output logic                     S_AXI_ARREADY,
   output aurora_pkg::word_t        S_AXI_RDATA,
   output logic                     S_AXI_RVALID,
   input  logic                     S_AXI_RREADY,
   // User streams
   input  logic                     s_axis_tvalid,
   input  aurora_pkg::word_t        s_axis_tdata,
   input  logic                     s_axis_tlast,
   output logic                     s_axis_tready,
   output logic                     m_axis_tvalid,
   output aurora_pkg::word_t        m_axis_tdata,
   output logic                     m_axis_tlast,
   // Link side of the transceiver core
   output logic                     link_tx_tvalid,
   output aurora_pkg::word_t        link_tx_tdata,
   output logic                     link_tx_tlast,
   input  logic                     link_tx_tready,
   input  logic                     link_rx_tvalid,
   input  aurora_pkg::word_t        link_rx_tdata,
   input  logic                     link_rx_tlast,
   input  logic                     channel_up
);
   import aurora_pkg::*;

   ctrl_reg_u ctrl;
   word_t     tx_pkt_cnt;
   word_t     rx_pkt_cnt;
   logic      overflow;

   stream_if loop_s ();  // Loopback FIFO toward the framer

   reg_slave u_reg_slave (
      .usr_clk, .S_AXI_ARESETN,
      .S_AXI_AWADDR, .S_AXI_AWVALID, .S_AXI_AWREADY,
      .S_AXI_WDATA, .S_AXI_WVALID, .S_AXI_WREADY,
      .S_AXI_BVALID, .S_AXI_BREADY,
      .S_AXI_ARADDR, .S_AXI_ARVALID, .S_AXI_ARREADY,
      .S_AXI_RDATA, .S_AXI_RVALID, .S_AXI_RREADY,
      .channel_up, .overflow, .tx_pkt_cnt, .rx_pkt_cnt, .ctrl
   );

   tx_framer u_tx_framer (
      .usr_clk, .S_AXI_ARESETN,
      .s_axis_tvalid, .s_axis_tdata, .s_axis_tlast, .s_axis_tready,
      .loop_s         (loop_s.snk),
      .loopback       (ctrl.f.loopback),
      .link_tx_tvalid, .link_tx_tdata, .link_tx_tlast, .link_tx_tready,
      .tx_pkt_cnt
   );

   loop_fifo u_loop_fifo (
      .usr_clk, .S_AXI_ARESETN,
      .link_rx_tvalid, .link_rx_tdata, .link_rx_tlast,
      .loop_s         (loop_s.src),
      .overflow
   );

   rx_strip u_rx_strip (
      .usr_clk, .S_AXI_ARESETN,
      .link_rx_tvalid, .link_rx_tdata, .link_rx_tlast,
      .strip_en       (ctrl.f.strip_en),
      .m_axis_tvalid, .m_axis_tdata, .m_axis_tlast,
      .rx_pkt_cnt
   );

endmodule

// ==== bench/tb_clkgen.sv ====
module tb_clkgen (
   output logic clk
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;  // 4 ns period
   end

endmodule

// ==== bench/aurora_shell_tb.sv ====
`include "aurora_macros.svh"

module aurora_shell_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import aurora_pkg::*;

   typedef enum logic [1:0] {OP_WR, OP_RD, OP_TX, OP_RX} op_e;
   typedef struct packed {
      op_e        op;
      logic [3:0] reg_idx;  // Register index for bus rows
      logic [7:0] len;      // Words per packet for stream rows
      word_t      data;     // Write data, expected read data or first packet word
   } row_t;

   localparam int N_ROWS     = 20;
   localparam int FIFO_WORDS = 1 << `LOOP_DEPTH_LOG2;

   logic                   usr_clk, S_AXI_ARESETN, channel_up;
   logic [`AXI_ADDR_W-1:0] S_AXI_AWADDR, S_AXI_ARADDR;
   logic                   S_AXI_AWVALID, S_AXI_AWREADY, S_AXI_WVALID, S_AXI_WREADY;
   logic                   S_AXI_BVALID, S_AXI_BREADY;
   logic                   S_AXI_ARVALID, S_AXI_ARREADY, S_AXI_RVALID, S_AXI_RREADY;
   word_t                  S_AXI_WDATA, S_AXI_RDATA, s_axis_tdata, m_axis_tdata;
   word_t                  link_tx_tdata, link_rx_tdata;
   logic                   s_axis_tvalid, s_axis_tlast, s_axis_tready;
   logic                   m_axis_tvalid, m_axis_tlast;
   logic                   link_tx_tvalid, link_tx_tlast, link_tx_tready;
   logic                   link_rx_tvalid, link_rx_tlast;

   row_t        rows [N_ROWS];
   logic [32:0] tx_seen [$];     // {tlast, tdata} taken by the link
   logic [32:0] rx_seen [$];     // Same for m_axis
   logic [32:0] got_q [$];
   logic [32:0] exp_q [$];
   logic [32:0] fifo_model [$];  // Link words the loopback FIFO should hold
   int          tx_rd, rx_rd;    // Read positions into the monitor queues
   int          val_errs, misc_errs, ready_errs, cycles, limit, tx_pkts;
   int          seed = 32'h47f2;
   logic [31:0] rnd;
   logic        strip_model, loop_model;
   word_t       rd_val;

   tb_clkgen u_clkgen (.clk(usr_clk));

   aurora_shell dut0 (.*);

   // Link back-pressure
   initial begin
      link_tx_tready = 1'b0;
      forever begin
         @(posedge usr_clk);
         #1;
         rnd = $random(seed);
         link_tx_tready = rnd[0];
      end
   end

   // Mid-cycle samples hold the values that meet the next rising edge
   always @(negedge usr_clk) begin
      if (link_tx_tvalid && link_tx_tready) tx_seen.push_back({link_tx_tlast, link_tx_tdata});
      if (m_axis_tvalid) rx_seen.push_back({m_axis_tlast, m_axis_tdata});
      assert (!(loop_model && s_axis_tready)) else begin
         ready_errs++;
         $display("s_axis_tready went high while loopback was set");
      end
   end

   always @(posedge usr_clk) begin
      cycles++;
      if (limit > 0 && cycles > limit) begin
         $display("Timeout: tests did not finish within %0d cycles", limit);
         $display("Errors: %0d value, %0d other", val_errs, misc_errs + ready_errs + 1);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   task automatic load_table;
      rows[0]  = '{OP_RD, `REG_CTRL,   8'd0,  32'h2};    // Strip on and loopback off
      rows[1]  = '{OP_RD, `REG_TX_CNT, 8'd0,  32'h0};
      rows[2]  = '{OP_TX, 4'd0,        8'd3,  32'h100};
      rows[3]  = '{OP_TX, 4'd0,        8'd1,  32'h200};
      rows[4]  = '{OP_TX, 4'd0,        8'd4,  32'h300};
      rows[5]  = '{OP_RX, 4'd0,        8'd4,  32'hA00};
      rows[6]  = '{OP_RX, 4'd0,        8'd1,  32'hB00};  // Lone sequence word gives no output
      rows[7]  = '{OP_WR, `REG_CTRL,   8'd0,  32'h0};
      rows[8]  = '{OP_RX, 4'd0,        8'd3,  32'hC00};
      rows[9]  = '{OP_RD, `REG_TX_CNT, 8'd0,  32'd3};
      rows[10] = '{OP_RD, `REG_RX_CNT, 8'd0,  32'd3};
      rows[11] = '{OP_RD, `REG_STAT,   8'd0,  32'h1};    // 8 words held without overflow
      rows[12] = '{OP_RX, 4'd0,        8'd10, 32'hD00};  // 18 received so two are dropped
      rows[13] = '{OP_RD, `REG_STAT,   8'd0,  32'h3};
      rows[14] = '{OP_WR, `REG_CTRL,   8'd0,  32'h1};    // Replay starts here
      rows[15] = '{OP_RD, `REG_CTRL,   8'd0,  32'h1};
      rows[16] = '{OP_RD, `REG_RX_CNT, 8'd0,  32'd4};
      rows[17] = '{OP_WR, `REG_CTRL,   8'd0,  32'h2};
      rows[18] = '{OP_TX, 4'd0,        8'd2,  32'h400};
      rows[19] = '{OP_RD, `REG_TX_CNT, 8'd0,  32'd4};
   endtask

   task automatic tick;
      @(posedge usr_clk);
      #1;
   endtask

   task automatic reg_write(input logic [3:0] idx, input word_t val);
      S_AXI_AWADDR  = {idx, 2'b00};
      S_AXI_WDATA   = val;
      S_AXI_AWVALID = 1'b1;
      S_AXI_WVALID  = 1'b1;
      S_AXI_BREADY  = 1'b1;
      while (!S_AXI_AWREADY) @(negedge usr_clk);
      assert (S_AXI_WREADY) else begin
         misc_errs++;
         $display("WREADY did not rise together with AWREADY");
      end
      tick();  // Accept edge
      S_AXI_AWVALID = 1'b0;
      S_AXI_WVALID  = 1'b0;
      while (!S_AXI_BVALID) @(negedge usr_clk);
      tick();
      S_AXI_BREADY = 1'b0;
   endtask

   task automatic reg_read(input logic [3:0] idx, output word_t val);
      S_AXI_ARADDR  = {idx, 2'b00};
      S_AXI_ARVALID = 1'b1;
      S_AXI_RREADY  = 1'b1;
      while (!S_AXI_ARREADY) @(negedge usr_clk);
      tick();
      S_AXI_ARVALID = 1'b0;
      while (!S_AXI_RVALID) @(negedge usr_clk);
      val = S_AXI_RDATA;
      tick();
      S_AXI_RREADY = 1'b0;
   endtask

   task automatic send_user(input int len, input word_t base);
      for (int i = 0; i < len; i++) begin
         s_axis_tvalid = 1'b1;
         s_axis_tdata  = base + i;
         s_axis_tlast  = (i == len - 1);
         @(negedge usr_clk);
         while (!s_axis_tready) @(negedge usr_clk);
         tick();
      end
      s_axis_tvalid = 1'b0;
      s_axis_tlast  = 1'b0;
   endtask

   task automatic drive_link(input int len, input word_t base);
      for (int i = 0; i < len; i++) begin
         link_rx_tvalid = 1'b1;
         link_rx_tdata  = base + i;
         link_rx_tlast  = (i == len - 1);
         tick();
      end
      link_rx_tvalid = 1'b0;
      link_rx_tlast  = 1'b0;
   endtask

   // Waits for the expected word count and two more cycles to catch extra words
   task automatic collect(input bit from_tx);
      int start;
      start = from_tx ? tx_rd : rx_rd;
      while ((from_tx ? tx_seen.size() : rx_seen.size()) < start + exp_q.size())
         @(posedge usr_clk);
      repeat (2) @(posedge usr_clk);
      #1;
      got_q.delete();
      if (from_tx) begin
         for (int i = tx_rd; i < tx_seen.size(); i++) got_q.push_back(tx_seen[i]);
         tx_rd = tx_seen.size();
      end else begin
         for (int i = rx_rd; i < rx_seen.size(); i++) got_q.push_back(rx_seen[i]);
         rx_rd = rx_seen.size();
      end
   endtask

   task automatic compare_stream(input string sig);
      logic [32:0] got;
      logic [32:0] exp;
      assert (got_q.size() == exp_q.size()) else begin
         misc_errs++;
         $display("%s carried %0d words where %0d were expected", sig, got_q.size(),
                  exp_q.size());
      end
      for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
         got = got_q[i];
         exp = exp_q[i];
         assert (got[31:0] == exp[31:0]) else begin
            val_errs++;
            $display("ERR %s_tdata: got %h, expected %h", sig, got[31:0], exp[31:0]);
         end
         assert (got[32] == exp[32]) else begin
            val_errs++;
            $display("ERR %s_tlast: got %h, expected %h", sig, got[32], exp[32]);
         end
      end
      exp_q.delete();
   endtask

   task automatic run_row(input row_t row);
      int          len;
      logic [32:0] w;
      len = int'(row.len);
      case (row.op)
         OP_WR: begin
            if (row.reg_idx == `REG_CTRL && !row.data[0]) loop_model = 1'b0;
            reg_write(row.reg_idx, row.data);
            if (row.reg_idx == `REG_CTRL) begin
               strip_model = row.data[1];
               if (row.data[0] && !loop_model) begin
                  loop_model = 1'b1;
                  exp_q = fifo_model;  // Everything held comes back in receive order
                  fifo_model.delete();
                  collect(1'b1);
                  compare_stream("link_tx");
               end
            end
         end
         OP_RD: begin
            reg_read(row.reg_idx, rd_val);
            assert (rd_val == row.data) else begin
               val_errs++;
               $display("ERR S_AXI_RDATA reg %0d: got %h, expected %h", row.reg_idx, rd_val,
                        row.data);
            end
         end
         OP_TX: begin
            for (int i = 0; i < len; i++) exp_q.push_back({1'b0, row.data + i});
            exp_q.push_back({1'b1, word_t'(tx_pkts)});  // Index of this packet
            send_user(len, row.data);
            tx_pkts++;
            collect(1'b1);
            compare_stream("link_tx");
         end
         default: begin
            for (int i = 0; i < len; i++) begin
               w = {(i == len - 1), row.data + i};
               if (fifo_model.size() < FIFO_WORDS) fifo_model.push_back(w);
               if (!strip_model) exp_q.push_back(w);
               else if (i < len - 1) exp_q.push_back({(i == len - 2), row.data + i});
            end
            drive_link(len, row.data);
            collect(1'b0);
            compare_stream("m_axis");
         end
      endcase
   endtask

   initial begin
      S_AXI_ARESETN  = 1'b0;
      channel_up     = 1'b1;
      S_AXI_AWADDR   = '0;
      S_AXI_AWVALID  = 1'b0;
      S_AXI_WDATA    = '0;
      S_AXI_WVALID   = 1'b0;
      S_AXI_BREADY   = 1'b0;
      S_AXI_ARADDR   = '0;
      S_AXI_ARVALID  = 1'b0;
      S_AXI_RREADY   = 1'b0;
      s_axis_tvalid  = 1'b0;
      s_axis_tdata   = '0;
      s_axis_tlast   = 1'b0;
      link_rx_tvalid = 1'b0;
      link_rx_tdata  = '0;
      link_rx_tlast  = 1'b0;
      strip_model    = `CTRL_RESET_STRIP;
      loop_model     = 1'b0;
      load_table();
      foreach (rows[r]) limit += int'(rows[r].len) + 20;
      repeat (8) @(posedge usr_clk);
      #1;
      S_AXI_ARESETN = 1'b1;
      for (int r = 0; r < N_ROWS; r++) run_row(rows[r]);
      $display("Errors: %0d value, %0d other", val_errs, misc_errs + ready_errs);
      if (val_errs + misc_errs + ready_errs == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

// ==== aurora_shell.f ====
+incdir+rtl
rtl/aurora_pkg.sv
rtl/stream_if.sv
rtl/reg_slave.sv
rtl/tx_framer.sv
rtl/loop_fifo.sv
rtl/rx_strip.sv
rtl/aurora_shell.sv
bench/tb_clkgen.sv
bench/aurora_shell_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
   -f aurora_shell.f --top-module aurora_shell_tb -o aurora_shell_sim

out=$(./obj_dir/aurora_shell_sim)
echo "$out"
if echo "$out" | grep -qx "TESTBENCH PASSED"; then
   exit 0
fi
exit 1
